// File: design/ex_ctrl_pkg.sv
// ======================================================================
// execute stage control encodings
// op classes, ALU functions, branch conditions, forwarding selects
// ======================================================================
package ex_ctrl_pkg;

	// op class from decode, follows the opcode field
	typedef enum logic [5:0] {
		ALU_OP_RTYPE = 6'b000000,
		ALU_OP_ADDI  = 6'b001000,
		ALU_OP_SLTI  = 6'b001010,
		ALU_OP_ANDI  = 6'b001100,
		ALU_OP_ORI   = 6'b001101,
		ALU_OP_XORI  = 6'b001110,
		ALU_OP_LUI   = 6'b001111,
		ALU_OP_MEM   = 6'b100000
	} alu_op_e;

	typedef enum logic [3:0] {
		ALU_FN_ADD   = 4'd0,
		ALU_FN_SUB   = 4'd1,
		ALU_FN_AND   = 4'd2,
		ALU_FN_OR    = 4'd3,
		ALU_FN_XOR   = 4'd4,
		ALU_FN_NOR   = 4'd5,
		ALU_FN_SLT   = 4'd6,
		ALU_FN_SLTU  = 4'd7,
		ALU_FN_SLL   = 4'd8,
		ALU_FN_SRL   = 4'd9,
		ALU_FN_SRA   = 4'd10,
		ALU_FN_LUI   = 4'd11,
		ALU_FN_PASSB = 4'd12
	} alu_fn_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6
	} branch_cond_e;

	// operand source, chosen by the hazard unit
	typedef enum logic [1:0] {
		FWD_RF       = 2'd0,
		FWD_MEM_ALU  = 2'd1,
		FWD_WB       = 2'd2,
		FWD_MEM_DATA = 2'd3
	} fwd_sel_e;

	typedef enum logic [1:0] {
		MFHL_NONE = 2'd0,
		MFHL_HI   = 2'd1,
		MFHL_LO   = 2'd2
	} mfhl_e;

endpackage

// File: design/ex_data_pkg.sv
// ======================================================================
// execute stage data width and payload structs
// ======================================================================
package ex_data_pkg;

	parameter int unsigned XLEN    = 32;
	parameter int unsigned RADDR_W = 5;

	// forwarding selects and the values they pick from
	typedef struct packed {
		ex_ctrl_pkg::fwd_sel_e sel_a;
		ex_ctrl_pkg::fwd_sel_e sel_b;
		logic [XLEN-1:0]       mem_alu;
		logic [XLEN-1:0]       wb_result;
		logic [XLEN-1:0]       mem_data_a;
		logic [XLEN-1:0]       mem_data_b;
	} fwd_bus_t;

	typedef struct packed {
		logic                      mem_read;
		logic                      mem_write;
		logic                      mem_to_reg;
		logic                      reg_write;
		logic                      link;
		logic                      reg_dst;
		logic                      alu_src;
		ex_ctrl_pkg::branch_cond_e branch_cond;
	} ex_ctrl_t;

	// EX/MEM payload
	typedef struct packed {
		logic [XLEN-1:0]    pc4;
		logic [XLEN-1:0]    alu_result;
		logic [XLEN-1:0]    store_data;
		logic [RADDR_W-1:0] dst;
		logic [RADDR_W-1:0] rt_addr;
		logic               mem_read;
		logic               mem_write;
		logic               mem_to_reg;
		logic               reg_write;
		logic               link;
		ex_ctrl_pkg::mfhl_e mfhl;
	} ex_mem_t;

endpackage

// File: design/alu_decoder.sv
`timescale 1ns/1ps
// ======================================================================
// ALU decoder, op class and funct to ALU function, mult and mfhi/mflo
// ======================================================================
module alu_decoder (
	input  ex_ctrl_pkg::alu_op_e i_alu_op,
	input  logic [5:0]           i_funct,
	output ex_ctrl_pkg::alu_fn_e o_fn,
	output logic                 o_mul,
	output ex_ctrl_pkg::mfhl_e   o_mfhl
);

	// R-type function codes
	localparam logic [5:0] F_SLL  = 6'b000000;
	localparam logic [5:0] F_SRL  = 6'b000010;
	localparam logic [5:0] F_SRA  = 6'b000011;
	localparam logic [5:0] F_MFHI = 6'b010000;
	localparam logic [5:0] F_MFLO = 6'b010010;
	localparam logic [5:0] F_MULT = 6'b011000;
	localparam logic [5:0] F_ADD  = 6'b100000;
	localparam logic [5:0] F_ADDU = 6'b100001;
	localparam logic [5:0] F_SUB  = 6'b100010;
	localparam logic [5:0] F_SUBU = 6'b100011;
	localparam logic [5:0] F_AND  = 6'b100100;
	localparam logic [5:0] F_OR   = 6'b100101;
	localparam logic [5:0] F_XOR  = 6'b100110;
	localparam logic [5:0] F_NOR  = 6'b100111;
	localparam logic [5:0] F_SLT  = 6'b101010;
	localparam logic [5:0] F_SLTU = 6'b101011;

	always_comb begin
		o_fn   = ex_ctrl_pkg::ALU_FN_ADD;
		o_mul  = 1'b0;
		o_mfhl = ex_ctrl_pkg::MFHL_NONE;
		case (i_alu_op)
			ex_ctrl_pkg::ALU_OP_RTYPE: begin
				case (i_funct)
					F_ADD, F_ADDU: o_fn = ex_ctrl_pkg::ALU_FN_ADD;
					F_SUB, F_SUBU: o_fn = ex_ctrl_pkg::ALU_FN_SUB;
					F_AND:         o_fn = ex_ctrl_pkg::ALU_FN_AND;
					F_OR:          o_fn = ex_ctrl_pkg::ALU_FN_OR;
					F_XOR:         o_fn = ex_ctrl_pkg::ALU_FN_XOR;
					F_NOR:         o_fn = ex_ctrl_pkg::ALU_FN_NOR;
					F_SLT:         o_fn = ex_ctrl_pkg::ALU_FN_SLT;
					F_SLTU:        o_fn = ex_ctrl_pkg::ALU_FN_SLTU;
					F_SLL:         o_fn = ex_ctrl_pkg::ALU_FN_SLL;
					F_SRL:         o_fn = ex_ctrl_pkg::ALU_FN_SRL;
					F_SRA:         o_fn = ex_ctrl_pkg::ALU_FN_SRA;
					F_MULT:        o_mul = 1'b1;
					F_MFHI: begin
						o_fn   = ex_ctrl_pkg::ALU_FN_PASSB;
						o_mfhl = ex_ctrl_pkg::MFHL_HI;
					end
					F_MFLO: begin
						o_fn   = ex_ctrl_pkg::ALU_FN_PASSB;
						o_mfhl = ex_ctrl_pkg::MFHL_LO;
					end
					default:       o_fn = ex_ctrl_pkg::ALU_FN_ADD;
				endcase
			end
			ex_ctrl_pkg::ALU_OP_ADDI: o_fn = ex_ctrl_pkg::ALU_FN_ADD;
			ex_ctrl_pkg::ALU_OP_ANDI: o_fn = ex_ctrl_pkg::ALU_FN_AND;
			ex_ctrl_pkg::ALU_OP_ORI:  o_fn = ex_ctrl_pkg::ALU_FN_OR;
			ex_ctrl_pkg::ALU_OP_XORI: o_fn = ex_ctrl_pkg::ALU_FN_XOR;
			ex_ctrl_pkg::ALU_OP_SLTI: o_fn = ex_ctrl_pkg::ALU_FN_SLT;
			ex_ctrl_pkg::ALU_OP_LUI:  o_fn = ex_ctrl_pkg::ALU_FN_LUI;
			// load and store address
			ex_ctrl_pkg::ALU_OP_MEM:  o_fn = ex_ctrl_pkg::ALU_FN_ADD;
			default:                  o_fn = ex_ctrl_pkg::ALU_FN_ADD;
		endcase
	end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
// ======================================================================
// 32-bit ALU, arithmetic, logic, compare and shifts
// ======================================================================
module alu (
	input  logic [ex_data_pkg::XLEN-1:0] i_a,
	input  logic [ex_data_pkg::XLEN-1:0] i_b,
	input  ex_ctrl_pkg::alu_fn_e         i_fn,
	input  logic [4:0]                   i_shamt,
	output logic [ex_data_pkg::XLEN-1:0] o_result
);

	logic [ex_data_pkg::XLEN-1:0] sum;
	logic [ex_data_pkg::XLEN-1:0] diff;
	logic                         lt_s;
	logic                         lt_u;

	// add and subtract wrap, no overflow trap
	assign sum  = i_a + i_b;
	assign diff = i_a - i_b;
	assign lt_s = $signed(i_a) < $signed(i_b);
	assign lt_u = i_a < i_b;

	always_comb begin
		case (i_fn)
			ex_ctrl_pkg::ALU_FN_ADD:   o_result = sum;
			ex_ctrl_pkg::ALU_FN_SUB:   o_result = diff;
			ex_ctrl_pkg::ALU_FN_AND:   o_result = i_a & i_b;
			ex_ctrl_pkg::ALU_FN_OR:    o_result = i_a | i_b;
			ex_ctrl_pkg::ALU_FN_XOR:   o_result = i_a ^ i_b;
			ex_ctrl_pkg::ALU_FN_NOR:   o_result = ~(i_a | i_b);
			ex_ctrl_pkg::ALU_FN_SLT: begin
				o_result = '0;
				o_result[0] = lt_s;
			end
			ex_ctrl_pkg::ALU_FN_SLTU: begin
				o_result = '0;
				o_result[0] = lt_u;
			end
			// shifts work on rt, as in sll rd, rt, sa
			ex_ctrl_pkg::ALU_FN_SLL:   o_result = i_b << i_shamt;
			ex_ctrl_pkg::ALU_FN_SRL:   o_result = i_b >> i_shamt;
			ex_ctrl_pkg::ALU_FN_SRA:   o_result = $unsigned($signed(i_b) >>> i_shamt);
			ex_ctrl_pkg::ALU_FN_LUI:   o_result = i_b << 16;
			ex_ctrl_pkg::ALU_FN_PASSB: o_result = i_b;
			default:                   o_result = sum;
		endcase
	end

endmodule

// File: design/operand_forward.sv
`timescale 1ns/1ps
// ======================================================================
// operand forwarding, ALU B source and destination register select
// ======================================================================
module operand_forward (
	input  logic [ex_data_pkg::XLEN-1:0]    i_rs_data,
	input  logic [ex_data_pkg::XLEN-1:0]    i_rt_data,
	input  logic [ex_data_pkg::XLEN-1:0]    i_imm_ext,
	input  logic [ex_data_pkg::RADDR_W-1:0] i_rt_addr,
	input  logic [ex_data_pkg::RADDR_W-1:0] i_rd_addr,
	input  logic                            i_reg_dst,
	input  logic                            i_alu_src,
	input  logic                            i_link,
	input  ex_data_pkg::fwd_bus_t           i_fwd,
	output logic [ex_data_pkg::XLEN-1:0]    o_op_a,
	output logic [ex_data_pkg::XLEN-1:0]    o_op_b,
	output logic [ex_data_pkg::XLEN-1:0]    o_alu_b,
	output logic [ex_data_pkg::RADDR_W-1:0] o_dst
);

	// one four-way selector, used for both operands
	function automatic logic [ex_data_pkg::XLEN-1:0] fwd_pick(
		input ex_ctrl_pkg::fwd_sel_e        sel,
		input logic [ex_data_pkg::XLEN-1:0] rf,
		input logic [ex_data_pkg::XLEN-1:0] mem_alu,
		input logic [ex_data_pkg::XLEN-1:0] wb,
		input logic [ex_data_pkg::XLEN-1:0] mem_data
	);
		case (sel)
			ex_ctrl_pkg::FWD_MEM_ALU:  return mem_alu;
			ex_ctrl_pkg::FWD_WB:       return wb;
			ex_ctrl_pkg::FWD_MEM_DATA: return mem_data;
			default:                   return rf;
		endcase
	endfunction

	assign o_op_a = fwd_pick(i_fwd.sel_a, i_rs_data, i_fwd.mem_alu, i_fwd.wb_result,
		i_fwd.mem_data_a);
	assign o_op_b = fwd_pick(i_fwd.sel_b, i_rt_data, i_fwd.mem_alu, i_fwd.wb_result,
		i_fwd.mem_data_b);

	assign o_alu_b = i_alu_src ? i_imm_ext : o_op_b;

	// jal links into r31
	assign o_dst = i_link ? ex_data_pkg::RADDR_W'(31) : (i_reg_dst ? i_rd_addr : i_rt_addr);

endmodule

// File: design/branch_compare.sv
`timescale 1ns/1ps
// ======================================================================
// branch condition check on the forwarded operands
// ======================================================================
module branch_compare (
	input  logic [ex_data_pkg::XLEN-1:0] i_op_a,
	input  logic [ex_data_pkg::XLEN-1:0] i_op_b,
	input  ex_ctrl_pkg::branch_cond_e    i_cond,
	output logic                         o_taken
);

	logic eq;
	logic neg;
	logic zero;

	assign eq   = (i_op_a == i_op_b);
	assign neg  = i_op_a[ex_data_pkg::XLEN-1];
	assign zero = (i_op_a == '0);

	always_comb begin
		case (i_cond)
			ex_ctrl_pkg::BR_EQ:  o_taken = eq;
			ex_ctrl_pkg::BR_NE:  o_taken = !eq;
			ex_ctrl_pkg::BR_LEZ: o_taken = neg || zero;
			ex_ctrl_pkg::BR_GTZ: o_taken = !neg && !zero;
			ex_ctrl_pkg::BR_LTZ: o_taken = neg;
			ex_ctrl_pkg::BR_GEZ: o_taken = !neg;
			default:             o_taken = 1'b0;
		endcase
	end

endmodule

// File: design/mult_unit.sv
`timescale 1ns/1ps
// ======================================================================
// multi-cycle signed multiplier with Hi/Lo and front-end stall
// ======================================================================
module mult_unit #(
	// stall length in cycles, start cycle included, at least 2
	parameter int unsigned MUL_CYCLES = 4
) (
	input  logic                         i_clk,
	input  logic                         i_nrst,
	input  logic                         i_start,
	input  logic [ex_data_pkg::XLEN-1:0] i_a,
	input  logic [ex_data_pkg::XLEN-1:0] i_b,
	output logic                         o_stall,
	output logic [ex_data_pkg::XLEN-1:0] o_hi,
	output logic [ex_data_pkg::XLEN-1:0] o_lo
);

	localparam int unsigned CNT_W = (MUL_CYCLES > 2) ? $clog2(MUL_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(MUL_CYCLES - 2);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_DONE
	} state_t;

	state_t                           state;
	logic [CNT_W-1:0]                 cnt;
	logic [ex_data_pkg::XLEN-1:0]     a_q;
	logic [ex_data_pkg::XLEN-1:0]     b_q;
	logic signed [2*ex_data_pkg::XLEN-1:0] prod;
	logic                             take;
	logic                             finish;

	assign take   = (state == ST_IDLE) && i_start;
	assign finish = (state == ST_BUSY) && (cnt == '0);
	assign prod   = $signed(a_q) * $signed(b_q);

	// stall rises in the start cycle itself
	assign o_stall = take || (state == ST_BUSY);

	// ==================================================================
	// control
	// ==================================================================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_BUSY;
						cnt   <= CNT_LOAD;
					end
				end
				ST_BUSY: begin
					if (cnt == '0) begin
						state <= ST_DONE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				// held mult is seen again here, do not restart
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			a_q <= i_a;
			b_q <= i_b;
		end
	end

	// ==================================================================
	// Hi/Lo
	// ==================================================================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_hi <= '0;
			o_lo <= '0;
		end else if (finish) begin
			o_hi <= prod[2*ex_data_pkg::XLEN-1:ex_data_pkg::XLEN];
			o_lo <= prod[ex_data_pkg::XLEN-1:0];
		end
	end

endmodule

// File: design/ex_mem_reg.sv
`timescale 1ns/1ps
// ======================================================================
// EX/MEM pipeline register, bubble while stalled
// ======================================================================
module ex_mem_reg (
	input  logic                 i_clk,
	input  logic                 i_nrst,
	input  logic                 i_stall,
	input  ex_data_pkg::ex_mem_t i_d,
	input  logic                 i_mul,
	output ex_data_pkg::ex_mem_t o_q
);

	ex_data_pkg::ex_mem_t d_gated;

	always_comb begin
		d_gated = i_d;
		// stall cycles become bubbles
		if (i_stall) begin
			d_gated.reg_write = 1'b0;
			d_gated.mem_read  = 1'b0;
			d_gated.mem_write = 1'b0;
			d_gated.link      = 1'b0;
		end
		// mult only writes Hi/Lo
		if (i_mul) begin
			d_gated.reg_write = 1'b0;
		end
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_q <= '0;
		end else begin
			o_q <= d_gated;
		end
	end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps
// ======================================================================
// execute stage, forwarding, branch resolve, ALU, multiplier, EX/MEM
// ======================================================================
module ex_stage #(
	parameter int unsigned MUL_CYCLES = 4
) (
	input  logic                            i_clk,
	input  logic                            i_nrst,
	input  logic [ex_data_pkg::XLEN-1:0]    i_pc4,
	input  logic [ex_data_pkg::XLEN-1:0]    i_rs_data,
	input  logic [ex_data_pkg::XLEN-1:0]    i_rt_data,
	input  logic [ex_data_pkg::XLEN-1:0]    i_imm_ext,
	input  logic [ex_data_pkg::RADDR_W-1:0] i_rt_addr,
	input  logic [ex_data_pkg::RADDR_W-1:0] i_rd_addr,
	input  ex_ctrl_pkg::alu_op_e            i_alu_op,
	input  ex_data_pkg::ex_ctrl_t           i_ctrl,
	input  ex_data_pkg::fwd_bus_t           i_fwd,
	output ex_data_pkg::ex_mem_t            o_ex_mem,
	output logic [ex_data_pkg::RADDR_W-1:0] o_ex_dst,
	output logic                            o_branch_taken,
	output logic                            o_stall,
	output logic [ex_data_pkg::XLEN-1:0]    o_hi,
	output logic [ex_data_pkg::XLEN-1:0]    o_lo
);

	logic [ex_data_pkg::XLEN-1:0]    op_a;
	logic [ex_data_pkg::XLEN-1:0]    op_b;
	logic [ex_data_pkg::XLEN-1:0]    alu_b;
	logic [ex_data_pkg::XLEN-1:0]    alu_result;
	logic [ex_data_pkg::RADDR_W-1:0] dst;
	ex_ctrl_pkg::alu_fn_e            alu_fn;
	ex_ctrl_pkg::mfhl_e              mfhl;
	logic                            mul;
	ex_data_pkg::ex_mem_t            ex_d;

	// ==================================================================
	// operands and branch
	// ==================================================================
	operand_forward operand_forward_inst (
		.i_rs_data (i_rs_data),
		.i_rt_data (i_rt_data),
		.i_imm_ext (i_imm_ext),
		.i_rt_addr (i_rt_addr),
		.i_rd_addr (i_rd_addr),
		.i_reg_dst (i_ctrl.reg_dst),
		.i_alu_src (i_ctrl.alu_src),
		.i_link    (i_ctrl.link),
		.i_fwd     (i_fwd),
		.o_op_a    (op_a),
		.o_op_b    (op_b),
		.o_alu_b   (alu_b),
		.o_dst     (dst)
	);

	branch_compare branch_compare_inst (
		.i_op_a  (op_a),
		.i_op_b  (op_b),
		.i_cond  (i_ctrl.branch_cond),
		.o_taken (o_branch_taken)
	);

	// ==================================================================
	// ALU and multiplier
	// ==================================================================
	alu_decoder alu_decoder_inst (
		.i_alu_op (i_alu_op),
		.i_funct  (i_imm_ext[5:0]),
		.o_fn     (alu_fn),
		.o_mul    (mul),
		.o_mfhl   (mfhl)
	);

	alu alu_inst (
		.i_a      (op_a),
		.i_b      (alu_b),
		.i_fn     (alu_fn),
		.i_shamt  (i_imm_ext[10:6]),
		.o_result (alu_result)
	);

	mult_unit #(
		.MUL_CYCLES (MUL_CYCLES)
	) mult_unit_inst (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.i_start (mul),
		.i_a     (op_a),
		.i_b     (op_b),
		.o_stall (o_stall),
		.o_hi    (o_hi),
		.o_lo    (o_lo)
	);

	// ==================================================================
	// EX/MEM
	// ==================================================================
	always_comb begin
		ex_d.pc4        = i_pc4;
		ex_d.alu_result = alu_result;
		ex_d.store_data = op_b;
		ex_d.dst        = dst;
		ex_d.rt_addr    = i_rt_addr;
		ex_d.mem_read   = i_ctrl.mem_read;
		ex_d.mem_write  = i_ctrl.mem_write;
		ex_d.mem_to_reg = i_ctrl.mem_to_reg;
		ex_d.reg_write  = i_ctrl.reg_write;
		ex_d.link       = i_ctrl.link;
		ex_d.mfhl       = mfhl;
	end

	ex_mem_reg ex_mem_reg_inst (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.i_stall (o_stall),
		.i_d     (ex_d),
		.i_mul   (mul),
		.o_q     (o_ex_mem)
	);

	// hazard unit needs the destination before the register
	assign o_ex_dst = dst;

endmodule

// File: verification/ex_stage_sva.sv
`timescale 1ns/1ps
// ======================================================================
// execute stage timing assertions, stall length, bubbles and Hi/Lo
// ======================================================================
module ex_stage_sva #(
	parameter int unsigned MUL_CYCLES = 4
) (
	input logic                         i_clk,
	input logic                         i_nrst,
	input logic                         i_stall,
	input logic                         i_mul,
	input ex_data_pkg::ex_mem_t         i_ex_mem,
	input logic [ex_data_pkg::XLEN-1:0] i_hi,
	input logic [ex_data_pkg::XLEN-1:0] i_lo
);

	int unsigned run_len;
	int unsigned fail_cnt = 0;

	// length of the current stall run
	always @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			run_len <= 0;
		end else if (i_stall) begin
			run_len <= run_len + 1;
		end else begin
			run_len <= 0;
		end
	end

	// ==================================================================
	// stall and bubbles
	// ==================================================================
	stall_len: assert property (@(posedge i_clk) disable iff (!i_nrst)
		$fell(i_stall) |-> run_len == MUL_CYCLES)
	else begin
		fail_cnt++;
		$error("stall run did not last MUL_CYCLES cycles");
	end

	bubble: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_stall |=> !(i_ex_mem.reg_write || i_ex_mem.mem_read ||
			i_ex_mem.mem_write || i_ex_mem.link))
	else begin
		fail_cnt++;
		$error("stall cycle did not leave a bubble in EX/MEM");
	end

	mul_no_write: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_mul |=> !i_ex_mem.reg_write)
	else begin
		fail_cnt++;
		$error("multiply reached EX/MEM with reg write set");
	end

	// ==================================================================
	// Hi/Lo move only on the edge that ends the stall
	// ==================================================================
	hilo_timing: assert property (@(posedge i_clk) disable iff (!i_nrst)
		($changed(i_hi) || $changed(i_lo)) |-> $fell(i_stall))
	else begin
		fail_cnt++;
		$error("Hi/Lo changed outside the end of a stall");
	end

endmodule

bind ex_stage ex_stage_sva #(
	.MUL_CYCLES (MUL_CYCLES)
) ex_stage_sva_inst (
	.i_clk    (i_clk),
	.i_nrst   (i_nrst),
	.i_stall  (o_stall),
	.i_mul    (mul),
	.i_ex_mem (o_ex_mem),
	.i_hi     (o_hi),
	.i_lo     (o_lo)
);

// File: verification/ex_stage_tb.sv
`timescale 1ns/1ps
// ======================================================================
// execute stage testbench driving random ALU, forward, branch and mult runs
// ======================================================================
module ex_stage_tb;

	localparam int MUL_CYCLES = 4;
	localparam int N_OPS      = 280;
	// about 300 instructions with mults of at most MUL_CYCLES+1 cycles
	localparam int MAX_CYCLES = 2000;

	logic                  clk;
	logic                  nrst;
	logic [31:0]           pc4;
	logic [31:0]           rs_data;
	logic [31:0]           rt_data;
	logic [31:0]           imm_ext;
	logic [4:0]            rt_addr;
	logic [4:0]            rd_addr;
	ex_ctrl_pkg::alu_op_e  alu_op;
	ex_data_pkg::ex_ctrl_t ctrl;
	ex_data_pkg::fwd_bus_t fwd;
	ex_data_pkg::ex_mem_t  ex_mem;
	logic [4:0]            ex_dst;
	logic                  branch_taken;
	logic                  stall;
	logic [31:0]           hi;
	logic [31:0]           lo;
	logic [31:0]           lfsr;
	int unsigned           err_cnt;
	int unsigned           cycle_cnt;

	ex_stage #(
		.MUL_CYCLES (MUL_CYCLES)
	) ex_stage_inst (
		.i_clk          (clk),
		.i_nrst         (nrst),
		.i_pc4          (pc4),
		.i_rs_data      (rs_data),
		.i_rt_data      (rt_data),
		.i_imm_ext      (imm_ext),
		.i_rt_addr      (rt_addr),
		.i_rd_addr      (rd_addr),
		.i_alu_op       (alu_op),
		.i_ctrl         (ctrl),
		.i_fwd          (fwd),
		.o_ex_mem       (ex_mem),
		.o_ex_dst       (ex_dst),
		.o_branch_taken (branch_taken),
		.o_stall        (stall),
		.o_hi           (hi),
		.o_lo           (lo)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run passed its cycle limit");
			$display("** FAIL **");
			$finish;
		end
	end

	// ==================================================================
	// random source and reference model
	// ==================================================================
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] pick_src(input logic [1:0] sel, input logic [31:0] rf,
		input logic [31:0] mem_data);
		case (sel)
			2'd1:    return fwd.mem_alu;
			2'd2:    return fwd.wb_result;
			2'd3:    return mem_data;
			default: return rf;
		endcase
	endfunction

	function automatic logic [31:0] model_alu(input logic [5:0] op, input logic [31:0] a,
		input logic [31:0] b);
		logic [4:0] sh;
		sh = imm_ext[10:6];
		case (op)
			6'b000000: begin
				case (imm_ext[5:0])
					6'h22, 6'h23: return a - b;
					6'h24:        return a & b;
					6'h25:        return a | b;
					6'h26:        return a ^ b;
					6'h27:        return ~(a | b);
					6'h2a:        return {31'd0, $signed(a) < $signed(b)};
					6'h2b:        return {31'd0, a < b};
					6'h00:        return b << sh;
					6'h02:        return b >> sh;
					6'h03:        return 32'({{32{b[31]}}, b} >> sh);
					6'h10, 6'h12: return b;
					default:      return a + b;
				endcase
			end
			6'b001010: return {31'd0, $signed(a) < $signed(b)};
			6'b001100: return a & b;
			6'b001101: return a | b;
			6'b001110: return a ^ b;
			6'b001111: return {b[15:0], 16'h0000};
			default:   return a + b;
		endcase
	endfunction

	function automatic logic model_branch(input logic [2:0] cond, input logic [31:0] a,
		input logic [31:0] b);
		case (cond)
			3'd1:    return a == b;
			3'd2:    return a != b;
			3'd3:    return $signed(a) <= 0;
			3'd4:    return $signed(a) > 0;
			3'd5:    return $signed(a) < 0;
			3'd6:    return $signed(a) >= 0;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// ==================================================================
	// stimulus
	// ==================================================================
	task automatic drive_random(input logic [5:0] op, input logic [5:0] funct);
		logic [1:0] mode;
		logic [2:0] cond;
		pc4     = rand_bits(32);
		rs_data = rand_bits(32);
		rt_data = rand_bits(32);
		imm_ext = rand_bits(32);
		rt_addr = rand_bits(5);
		rd_addr = rand_bits(5);
		alu_op  = ex_ctrl_pkg::alu_op_e'(op);
		fwd.sel_a      = ex_ctrl_pkg::fwd_sel_e'(rand_bits(2));
		fwd.sel_b      = ex_ctrl_pkg::fwd_sel_e'(rand_bits(2));
		fwd.mem_alu    = rand_bits(32);
		fwd.wb_result  = rand_bits(32);
		fwd.mem_data_a = rand_bits(32);
		fwd.mem_data_b = rand_bits(32);
		mode = rand_bits(2);
		// zero, equal and negative operands for the branch checks
		if (mode == 2'd0) begin
			fwd.sel_a = ex_ctrl_pkg::FWD_RF;
			rs_data   = '0;
		end else if (mode == 2'd1) begin
			fwd.sel_a = ex_ctrl_pkg::FWD_RF;
			fwd.sel_b = ex_ctrl_pkg::FWD_RF;
			rt_data   = rs_data;
		end
		cond = rand_bits(3);
		if (cond == 3'd7) begin
			cond = 3'd0;
		end
		ctrl = ex_data_pkg::ex_ctrl_t'(rand_bits(7) << 3);
		ctrl.link        = (rand_bits(3) == 0);
		ctrl.alu_src     = (op != 6'b000000);
		ctrl.branch_cond = ex_ctrl_pkg::branch_cond_e'(cond);
		if (op == 6'b000000) begin
			imm_ext[5:0] = funct;
		end
	endtask

	task automatic apply_and_check();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [4:0]  dst;
		logic [1:0]  mfhl;
		a   = pick_src(fwd.sel_a, rs_data, fwd.mem_data_a);
		b   = pick_src(fwd.sel_b, rt_data, fwd.mem_data_b);
		res = model_alu(alu_op, a, ctrl.alu_src ? imm_ext : b);
		dst = ctrl.link ? 5'd31 : (ctrl.reg_dst ? rd_addr : rt_addr);
		mfhl = 2'd0;
		if (alu_op == ex_ctrl_pkg::ALU_OP_RTYPE && imm_ext[5:0] == 6'h10) begin
			mfhl = 2'd1;
		end else if (alu_op == ex_ctrl_pkg::ALU_OP_RTYPE && imm_ext[5:0] == 6'h12) begin
			mfhl = 2'd2;
		end
		#40;
		check_val("o_branch_taken", 32'(branch_taken), 32'(model_branch(ctrl.branch_cond,
			a, b)));
		check_val("o_ex_dst", 32'(ex_dst), 32'(dst));
		@(posedge clk);
		#5;
		check_val("alu_result", ex_mem.alu_result, res);
		check_val("store_data", ex_mem.store_data, b);
		check_val("pc4", ex_mem.pc4, pc4);
		check_val("dst", 32'(ex_mem.dst), 32'(dst));
		check_val("rt_addr", 32'(ex_mem.rt_addr), 32'(rt_addr));
		check_val("ctrl bits", {27'd0, ex_mem.mem_read, ex_mem.mem_write,
			ex_mem.mem_to_reg, ex_mem.reg_write, ex_mem.link}, {27'd0, ctrl.mem_read,
			ctrl.mem_write, ctrl.mem_to_reg, ctrl.reg_write, ctrl.link});
		check_val("mfhl", 32'(ex_mem.mfhl), 32'(mfhl));
	endtask

	task automatic mult_test();
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        prod;
		int                 n;
		drive_random(6'b000000, 6'h18);
		ctrl.reg_write = 1'b1;
		sa   = {{32{1'b0}}, pick_src(fwd.sel_a, rs_data, fwd.mem_data_a)};
		sb   = {{32{1'b0}}, pick_src(fwd.sel_b, rt_data, fwd.mem_data_b)};
		sa   = {{32{sa[31]}}, sa[31:0]};
		sb   = {{32{sb[31]}}, sb[31:0]};
		prod = sa * sb;
		n    = 1;
		#40;
		check_val("o_stall", 32'(stall), 32'd1);
		forever begin
			@(posedge clk);
			#5;
			check_val("bubble ctrl", {28'd0, ex_mem.reg_write, ex_mem.mem_read,
				ex_mem.mem_write, ex_mem.link}, 32'd0);
			if (!stall) begin
				break;
			end
			n++;
			if (n > MUL_CYCLES + 4) begin
				err_cnt++;
				$display("multiply stall never ended");
				break;
			end
		end
		check_val("stall cycles", 32'(n), 32'(MUL_CYCLES));
		check_val("o_hi", hi, prod[63:32]);
		check_val("o_lo", lo, prod[31:0]);
		// held multiply is seen once more and leaves with no reg write
		@(posedge clk);
		#5;
		check_val("mult reg_write", 32'(ex_mem.reg_write), 32'd0);
		check_val("mult mfhl", 32'(ex_mem.mfhl), 32'd0);
	endtask

	// ==================================================================
	// main sequence
	// ==================================================================
	initial begin
		logic [5:0] op_list[8];
		logic [5:0] fn_list[13];
		logic [2:0] k;
		logic [3:0] f;
		op_list = '{6'h00, 6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20};
		fn_list = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
			6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
		lfsr      = 32'h4e88_7fe5;
		err_cnt   = 0;
		cycle_cnt = 0;
		clk       = 1'b0;
		nrst      = 1'b0;
		pc4       = '0;
		rs_data   = '0;
		rt_data   = '0;
		imm_ext   = '0;
		rt_addr   = '0;
		rd_addr   = '0;
		alu_op    = ex_ctrl_pkg::ALU_OP_RTYPE;
		ctrl      = '0;
		fwd       = '0;
		repeat (4) @(posedge clk);
		#5;
		check_val("reset ctrl", {25'd0, ex_mem.mem_read, ex_mem.mem_write,
			ex_mem.mem_to_reg, ex_mem.reg_write, ex_mem.link, ex_mem.mfhl}, 32'd0);
		check_val("reset o_stall", 32'(stall), 32'd0);
		check_val("reset o_hi", hi, 32'd0);
		check_val("reset o_lo", lo, 32'd0);
		nrst = 1'b1;
		for (int i = 0; i < N_OPS; i++) begin
			if (i % 25 == 24) begin
				mult_test();
				drive_random(6'b000000, 6'h10);
				apply_and_check();
				drive_random(6'b000000, 6'h12);
				apply_and_check();
			end else begin
				k = rand_bits(3);
				f = rand_bits(4);
				if (f > 4'd12) begin
					f = f - 4'd8;
				end
				drive_random(op_list[k], fn_list[f]);
				apply_and_check();
			end
		end
		$display("errors: checks %0d assertions %0d", err_cnt,
			ex_stage_inst.ex_stage_sva_inst.fail_cnt);
		if (err_cnt == 0 && ex_stage_inst.ex_stage_sva_inst.fail_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: ex_stage.f
design/ex_ctrl_pkg.sv
design/ex_data_pkg.sv
design/alu_decoder.sv
design/alu.sv
design/operand_forward.sv
design/branch_compare.sv
design/mult_unit.sv
design/ex_mem_reg.sv
design/ex_stage.sv
verification/ex_stage_sva.sv
verification/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f ex_stage.f --top-module ex_stage_tb \
	-Mdir obj_dir -o ex_stage_sim || exit 1
out=$(./obj_dir/ex_stage_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*' && exit 0 || exit 1
